// ==== all.f ====
pat_pkg.sv
pat_exec_if.sv
pat_pc.sv
pat_regfile.sv
pat_decode.sv
pat_alu.sv
pat_commit.sv
pat_top.sv
tb_pat.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then judge the run from its log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pat -f all.f -o sim_pat \
	&& ./obj_dir/sim_pat > sim.log 2>&1
cat sim.log 2>/dev/null
test -s sim.log && ! grep -q "SIMULATION FAILED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

// ==== tb_pat.sv ====
`default_nettype none

module tb_pat;
	timeunit 1ns;
	timeprecision 100ps;
	import pat_pkg::*;

	localparam int i_adr_width = 10;
	localparam int reset_cycles = 16;

	logic clk;
	logic reset;
	instr_t i_instruction;
	data_t i_in0;
	data_t i_in1;
	data_t i_in2;
	logic [i_adr_width-1:0] o_pc;
	data_t o_out;
	logic o_out_strobe;

	instr_t prog [$]; // program rom indexed by o_pc
	data_t expected [$]; // one entry per out that must strobe
	string test_name [$]; // section each expected entry belongs to
	string cur_test;
	data_t in_value [3];
	logic [31:0] lfsr_state;
	int out_count = 0;
	int cycle_count = 0;
	int timeout_limit;
	int loop_pc; // address of the final branch to itself
	int loop_hits;

	pat_top #(.i_adr_width(i_adr_width)) uut (
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.i_in0(i_in0),
		.i_in1(i_in1),
		.i_in2(i_in2),
		.o_pc(o_pc),
		.o_out(o_out),
		.o_out_strobe(o_out_strobe)
	);

	// ========================================
	// helpers
	// ========================================
	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_byte(output data_t b);
		for (int k = 0; k < d_width; k++)
		begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			b = {b[d_width-2:0], lfsr_state[0]};
		end
	endtask

	// rn, reserved, cond, reserved, opcode, imm8
	function automatic instr_t i8_word(input rf_addr_t rn, input op_i8_e op, input data_t imm);
		return {rn, 5'b0, 2'b0, 1'b0, op, imm};
	endfunction

	function automatic instr_t bf_word(input cond_e c, input data_t offset);
		return {3'd0, 5'b0, c, 1'b0, op_bf, offset}; // offset counts from the bf
	endfunction

	function automatic instr_t i3_word(input rf_addr_t rn, input op_i3_e op, input logic [2:0] imm3);
		return {rn, 5'b0, 2'b0, 1'b0, prefix_op, op, 1'b0, imm3};
	endfunction

	function automatic instr_t i0_word(input rf_addr_t rn, input op_i0_e op);
		return {rn, 5'b0, 2'b0, 1'b0, prefix_op, prefix_op, op};
	endfunction

	function automatic instr_t rom_word(input logic [i_adr_width-1:0] a);
		if (a < prog.size())
			return prog[a];
		return instr_nop; // only fetched behind the final bf
	endfunction

	task automatic add_word(input instr_t w);
		prog.push_back(w);
	endtask

	task automatic add_out(input rf_addr_t rn, input data_t value);
		add_word(i3_word(rn, op_out, 3'd0));
		expected.push_back(value);
		test_name.push_back(cur_test);
	endtask

	// ========================================
	// program and expected outputs
	// ========================================
	task automatic build_program();
		instr_t skip_word;
		skip_word = i3_word(3'd5, op_out, 3'd0); // must never strobe
		cur_test = "immediate ops";
		add_word(i8_word(3'd1, op_ldi, 8'h5a));
		add_out(3'd1, 8'h5a);
		add_word(i8_word(3'd1, op_ori, 8'h81));
		add_out(3'd1, 8'hdb);
		add_word(i8_word(3'd1, op_andi, 8'h0f));
		add_out(3'd1, 8'h0b);
		add_word(i8_word(3'd1, op_addi, 8'hf9)); // carry out dropped
		add_out(3'd1, 8'h04);
		add_word(i8_word(3'd1, op_subi, 8'h07));
		add_out(3'd1, 8'hfd);
		add_word(i0_word(3'd1, op_not));
		add_out(3'd1, 8'h02);
		cur_test = "register ops";
		add_word(i8_word(3'd2, op_ldi, 8'h30));
		add_word(i8_word(3'd3, op_ldi, 8'h5c)); // acc = 5c
		add_word(i8_word(3'd2, op_orr, 8'h00)); // 5c | 30
		add_out(3'd2, 8'h7c);
		add_word(i8_word(3'd3, op_andr, 8'h00)); // 7c & 5c
		add_out(3'd3, 8'h5c);
		add_word(i8_word(3'd2, op_addr, 8'h00)); // 5c + 7c
		add_out(3'd2, 8'hd8);
		add_word(i8_word(3'd2, op_subr, 8'h00)); // d8 - d8 leaves r2 zero for the test on z
		add_out(3'd2, 8'h00);
		cur_test = "forwarding";
		add_word(i8_word(3'd5, op_ldi, 8'h11));
		add_word(i8_word(3'd5, op_addi, 8'h22)); // 33
		add_word(i8_word(3'd5, op_addr, 8'h00)); // acc 33 + r5 33
		add_word(i8_word(3'd5, op_subi, 8'h07)); // 66 - 07
		add_out(3'd5, 8'h5f);
		cur_test = "immediate shifts";
		add_word(i8_word(3'd6, op_ldi, 8'h96));
		add_word(i3_word(3'd6, op_shloi, 3'd2)); // by 3 with ones in
		add_out(3'd6, 8'hb7);
		add_word(i3_word(3'd6, op_asri, 3'd1)); // by 2 keeping the sign
		add_out(3'd6, 8'hed);
		add_word(i3_word(3'd6, op_shrzi, 3'd0)); // by 1
		add_out(3'd6, 8'h76);
		add_word(i3_word(3'd6, op_shlzi, 3'd3)); // by 4
		add_out(3'd6, 8'h60);
		cur_test = "register shifts";
		add_word(i8_word(3'd7, op_ldi, 8'h00));
		add_word(i8_word(3'd0, op_ldi, 8'hc5)); // acc = c5
		add_word(i3_word(3'd7, op_asrr, 3'd0)); // c5 by 1
		add_out(3'd7, 8'he2);
		add_word(i3_word(3'd7, op_shlor, 3'd0)); // e2 by 3
		add_out(3'd7, 8'h17);
		add_word(i3_word(3'd7, op_shlzr, 3'd0)); // 17 by 4
		add_out(3'd7, 8'h70);
		add_word(i3_word(3'd7, op_shrzr, 3'd0)); // 70 by 1
		add_out(3'd7, 8'h38);
		cur_test = "input select";
		add_word(i3_word(3'd1, op_in, 3'b001));
		add_out(3'd1, in_value[0]);
		add_word(i3_word(3'd1, op_in, 3'b010));
		add_out(3'd1, in_value[1]);
		add_word(i3_word(3'd1, op_in, 3'b100));
		add_out(3'd1, in_value[2]);
		add_word(i3_word(3'd1, op_in, 3'b000)); // no select bit gives input 0
		add_out(3'd1, in_value[0]);
		cur_test = "branching";
		add_word(i8_word(3'd4, op_ldi, 8'h80));
		add_word(i0_word(3'd2, op_test)); // z set
		add_word(bf_word(cond_z, 8'd3));
		add_word(skip_word);
		add_word(skip_word);
		add_word(i0_word(3'd6, op_test)); // z and n clear
		add_word(bf_word(cond_z, 8'd3)); // falls through
		add_out(3'd6, 8'h60);
		add_word(bf_word(cond_nz, 8'd3));
		add_word(skip_word);
		add_word(skip_word);
		add_word(i0_word(3'd4, op_test)); // n set
		add_word(bf_word(cond_n, 8'd3));
		add_word(skip_word);
		add_word(skip_word);
		add_word(i0_word(3'd6, op_test));
		add_word(bf_word(cond_n, 8'd3)); // falls through
		add_out(3'd3, 8'h5c);
		loop_pc = prog.size();
		add_word(bf_word(cond_al, 8'd0)); // spin here
	endtask

	// ========================================
	// clock, stimulus, checks
	// ========================================
	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		i_instruction = instr_nop;
		i_in0 = '0;
		i_in1 = '0;
		i_in2 = '0;
		lfsr_state = 32'he5f8;
		for (int k = 0; k < 3; k++)
			draw_byte(in_value[k]);
		build_program();
		// a word per cycle and two more per taken branch fit in twice the size
		timeout_limit = reset_cycles + 2 * prog.size() + 10;
		repeat (reset_cycles)
		begin
			@(posedge clk);
			#1;
			i_instruction = rom_word(o_pc);
			a_reset_state: assert (o_pc == '0 && o_out_strobe == 1'b0)
				else fail_stop("pc or output strobe not cleared during reset");
		end
		reset = 1'b0;
		i_in0 = in_value[0];
		i_in1 = in_value[1];
		i_in2 = in_value[2];
		@(posedge clk);
		#1;
		i_instruction = rom_word(o_pc);
		a_first_cycle: assert (o_pc == 1 && o_out_strobe == 1'b0)
			else fail_stop("pc did not step to 1 or strobe set in the first cycle after reset");
		loop_hits = 0;
		while (loop_hits < 2) // second fetch of the final bf comes after the redirect
		begin
			@(posedge clk);
			#1;
			i_instruction = rom_word(o_pc);
			if (o_pc == loop_pc)
				loop_hits++;
		end
		if (out_count == expected.size())
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
		else
			fail_stop($sformatf("final loop reached after %0d output strobes, %0d expected",
				out_count, expected.size()));
	end

	// strobe is stable around the falling edge
	always @(negedge clk)
	begin
		if (o_out_strobe)
		begin
			a_strobe_count: assert (out_count < expected.size())
				else fail_stop("output strobe with no expected value left, a skipped out fired");
			a_out_value: assert (o_out == expected[out_count])
				else fail_stop($sformatf("Error: %s expected 0x%02h actual 0x%02h",
					test_name[out_count], expected[out_count], o_out));
			out_count++;
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > timeout_limit)
			fail_stop($sformatf("timeout after %0d cycles, final loop never reached", cycle_count));
	end

endmodule

`default_nettype wire

// ==== pat_top.sv ====
`default_nettype none

module pat_top #(
	parameter int i_adr_width = 10
) (
	input wire clk,
	input wire reset,
	input wire pat_pkg::instr_t i_instruction, // rom word for o_pc
	input wire pat_pkg::data_t i_in0,
	input wire pat_pkg::data_t i_in1,
	input wire pat_pkg::data_t i_in2,
	output logic [i_adr_width-1:0] o_pc,
	output pat_pkg::data_t o_out,
	output logic o_out_strobe
);
	import pat_pkg::*;

	logic wr_en;
	rf_addr_t wr_addr;
	data_t wr_data;
	data_t acc;
	logic taken;
	logic [i_adr_width-1:0] target;
	rf_addr_t rd_addr;
	data_t rd_data;
	data_t reg_y; // acc op register
	data_t imm_y; // register or input op immediate

	pat_exec_if #(.i_adr_width(i_adr_width)) exec ();

	pat_pc #(.i_adr_width(i_adr_width)) u_pc (
		.clk(clk), .reset(reset), .i_taken(taken), .i_target(target), .o_pc(o_pc)
	);

	pat_regfile u_regfile (
		.clk(clk), .i_rd_addr(rd_addr), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
		.i_wr_data(wr_data), .o_rd_data(rd_data)
	);

	pat_decode #(.i_adr_width(i_adr_width)) u_decode (
		.clk(clk), .reset(reset), .i_instruction(i_instruction), .i_pc(o_pc),
		.i_rd_data(rd_data), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_taken(taken), .i_in0(i_in0), .i_in1(i_in1), .i_in2(i_in2),
		.o_rd_addr(rd_addr), .exec(exec)
	);

	pat_alu reg_alu (.i_op(exec.alu_op), .i_a(acc), .i_b(exec.reg_value), .o_y(reg_y));

	pat_alu imm_alu (.i_op(exec.alu_op), .i_a(exec.src_value), .i_b(exec.imm_value), .o_y(imm_y));

	pat_commit #(.i_adr_width(i_adr_width)) u_commit (
		.clk(clk), .reset(reset), .i_reg_y(reg_y), .i_imm_y(imm_y), .exec(exec),
		.o_acc(acc), .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
		.o_taken(taken), .o_target(target), .o_out(o_out), .o_out_strobe(o_out_strobe)
	);

endmodule

`default_nettype wire

// ==== pat_commit.sv ====
`default_nettype none

module pat_commit #(
	parameter int i_adr_width = 10
) (
	input wire clk,
	input wire reset,
	input wire pat_pkg::data_t i_reg_y,
	input wire pat_pkg::data_t i_imm_y,
	pat_exec_if.commit exec,
	output pat_pkg::data_t o_acc,
	output logic o_wr_en,
	output pat_pkg::rf_addr_t o_wr_addr,
	output pat_pkg::data_t o_wr_data,
	output logic o_taken,
	output logic [i_adr_width-1:0] o_target,
	output pat_pkg::data_t o_out,
	output logic o_out_strobe
);
	import pat_pkg::*;

	data_t result;
	logic flag_z;
	logic flag_n;
	logic cond_ok;

	// ========================================
	// result steering in the execute cycle
	// ========================================
	assign result = exec.use_imm ? i_imm_y : i_reg_y;

	always_comb
	begin
		case (exec.cond)
			cond_z: cond_ok = flag_z;
			cond_nz: cond_ok = !flag_z;
			cond_n: cond_ok = flag_n;
			default: cond_ok = 1'b1; // always
		endcase
	end

	assign o_wr_en = exec.ex_valid && (exec.dest == dest_reg);
	assign o_wr_addr = exec.rd;
	assign o_wr_data = result;
	assign o_taken = exec.ex_valid && (exec.dest == dest_branch) && cond_ok;
	// offset counts from the bf itself
	assign o_target = exec.ex_pc + i_adr_width'($signed(exec.imm_value));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			o_out_strobe <= 1'b0;
		end
		else
		begin
			o_out_strobe <= exec.ex_valid && (exec.dest == dest_out); // one cycle pulse
			if (o_wr_en)
				o_acc <= result; // acc tracks the last register write
			if (exec.ex_valid && (exec.dest == dest_flags))
			begin
				flag_z <= (result == '0);
				flag_n <= result[d_width-1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (exec.ex_valid && (exec.dest == dest_out))
			o_out <= result;
	end

	// a taken bf must annul the instruction behind it in decode
	a_taken_annuls: assert property (@(posedge clk) disable iff (reset)
		o_taken |=> !exec.ex_valid)
		else $error("pat_commit: instruction after taken branch not annulled");

	// an out must read a register that was written before
	a_out_known: assert property (@(posedge clk) disable iff (reset)
		o_out_strobe |-> !$isunknown(o_out))
		else $error("pat_commit: output strobe with unknown data");

endmodule

`default_nettype wire

// ==== pat_alu.sv ====
`default_nettype none

module pat_alu (
	input wire pat_pkg::alu_op_e i_op,
	input wire pat_pkg::data_t i_a,
	input wire pat_pkg::data_t i_b,
	output pat_pkg::data_t o_y
);
	import pat_pkg::*;

	logic [2:0] amount; // shifts move by one to four places

	assign amount = {1'b0, i_b[1:0]} + 3'd1;

	always_comb
	begin
		case (i_op)
			alu_pass_b: o_y = i_b;
			alu_or: o_y = i_a | i_b;
			alu_and: o_y = i_a & i_b;
			alu_add: o_y = i_a + i_b;
			alu_sub: o_y = i_a - i_b;
			alu_not: o_y = ~i_a;
			alu_shlz: o_y = i_a << amount;
			// shifting the inverse brings in zeros, inverting back gives ones
			alu_shlo: o_y = ~((~i_a) << amount);
			alu_shrz: o_y = i_a >> amount;
			alu_asr: o_y = data_t'($signed(i_a) >>> amount); // sign bit copied down
			default: o_y = i_a; // pass_a
		endcase
	end

endmodule

`default_nettype wire

// ==== pat_decode.sv ====
`default_nettype none

module pat_decode #(
	parameter int i_adr_width = 10
) (
	input wire clk,
	input wire reset,
	input wire pat_pkg::instr_t i_instruction,
	input wire [i_adr_width-1:0] i_pc,
	input wire pat_pkg::data_t i_rd_data,
	input wire i_wr_en, // commit write, used for forwarding
	input wire pat_pkg::rf_addr_t i_wr_addr,
	input wire pat_pkg::data_t i_wr_data,
	input wire i_taken,
	input wire pat_pkg::data_t i_in0,
	input wire pat_pkg::data_t i_in1,
	input wire pat_pkg::data_t i_in2,
	output pat_pkg::rf_addr_t o_rd_addr,
	pat_exec_if.decode exec
);
	import pat_pkg::*;

	instr_t instr_q; // decode stage instruction
	logic [i_adr_width-1:0] pc_q;
	logic valid_q;
	logic [op_width-1:0] opcode_i8;
	logic [op_width-1:0] opcode_i3;
	logic [op_width-1:0] opcode_i0;
	logic is_i8;
	logic is_i3;
	rf_addr_t rn;
	data_t imm8;
	logic [imm3_width-1:0] imm3;
	data_t fwd_data; // rn value including the result now committing
	data_t in_data;
	alu_op_e dec_op;
	dest_e dec_dest;
	logic dec_imm;
	logic dec_in;

	// ========================================
	// field split and tier select
	// ========================================
	assign imm8 = instr_q[imm8_lsb +: d_width];
	assign opcode_i8 = instr_q[op_i8_lsb +: op_width];
	assign opcode_i3 = imm8[op_i3_lsb +: op_width];
	assign opcode_i0 = imm8[op_i0_lsb +: op_width];
	assign imm3 = imm8[imm3_width-1:0];
	assign rn = instr_q[rn_lsb +: $bits(rf_addr_t)];
	assign is_i8 = (opcode_i8 != prefix_op);
	assign is_i3 = !is_i8 && (opcode_i3 != prefix_op); // neither -> i0

	assign o_rd_addr = rn;
	// one-deep bypass, older results are already in the regfile
	assign fwd_data = (i_wr_en && (i_wr_addr == rn)) ? i_wr_data : i_rd_data;

	always_comb
	begin
		case (imm3) // one-hot, anything else reads input 0
			3'b010: in_data = i_in1;
			3'b100: in_data = i_in2;
			default: in_data = i_in0;
		endcase
	end

	always_comb
	begin
		dec_op = alu_pass_a;
		dec_dest = dest_none;
		dec_imm = 1'b1; // immediate alu unless a reg form
		dec_in = 1'b0;
		if (is_i8)
		begin
			dec_imm = !opcode_i8[0] || opcode_i8[3]; // odd low codes are acc op reg
			dec_dest = (opcode_i8 <= op_ldi) ? dest_reg : dest_none;
			case (opcode_i8)
				op_ori, op_orr: dec_op = alu_or;
				op_andi, op_andr: dec_op = alu_and;
				op_addi, op_addr: dec_op = alu_add;
				op_subi, op_subr: dec_op = alu_sub;
				op_ldi: dec_op = alu_pass_b; // immediate straight through
				op_bf: dec_dest = dest_branch;
				default: dec_dest = dest_none; // spare i8 codes
			endcase
		end
		else if (is_i3)
		begin
			dec_imm = !opcode_i3[0] || opcode_i3[3];
			dec_dest = dest_reg;
			case (opcode_i3)
				op_shlzi, op_shlzr: dec_op = alu_shlz;
				op_shloi, op_shlor: dec_op = alu_shlo;
				op_shrzi, op_shrzr: dec_op = alu_shrz;
				op_asri, op_asrr: dec_op = alu_asr;
				op_in: dec_in = 1'b1; // pass_a of the picked input
				op_out: dec_dest = dest_out; // pass_a of rn
				default: dec_dest = dest_none;
			endcase
		end
		else
		begin
			case (opcode_i0)
				op_not:
				begin
					dec_op = alu_not;
					dec_dest = dest_reg;
				end
				op_test: dec_dest = dest_flags;
				default: dec_dest = dest_none; // nop and spare i0 codes
			endcase
		end
	end

	// ========================================
	// stage registers
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_q <= 1'b0;
			exec.ex_valid <= 1'b0;
		end
		else
		begin
			valid_q <= !i_taken; // word fetched behind a taken bf dies
			exec.ex_valid <= valid_q && !i_taken; // and so does the one in decode
		end
	end

	always_ff @(posedge clk)
	begin
		instr_q <= i_instruction;
		pc_q <= i_pc;
		exec.alu_op <= dec_op;
		exec.use_imm <= dec_imm;
		exec.dest <= dec_dest;
		exec.cond <= cond_e'(instr_q[cond_lsb +: $bits(cond_e)]);
		exec.rd <= rn;
		exec.reg_value <= fwd_data;
		exec.src_value <= dec_in ? in_data : fwd_data;
		exec.imm_value <= is_i8 ? imm8 : d_width'(imm3); // shift amount in low two bits
		exec.ex_pc <= pc_q;
	end

endmodule

`default_nettype wire

// ==== pat_regfile.sv ====
`default_nettype none

module pat_regfile (
	input wire clk,
	input wire pat_pkg::rf_addr_t i_rd_addr,
	input wire i_wr_en,
	input wire pat_pkg::rf_addr_t i_wr_addr,
	input wire pat_pkg::data_t i_wr_data,
	output pat_pkg::data_t o_rd_data
);
	import pat_pkg::*;

	data_t mem [rf_depth]; // r0..r7

	assign o_rd_data = mem[i_rd_addr]; // async read in decode

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data; // commit edge write
	end

	// address is driven from the execute stage register in decode
	a_wr_addr_known: assert property (@(posedge clk)
		i_wr_en |-> !$isunknown(i_wr_addr))
		else $error("pat_regfile: write with unknown address");

endmodule

`default_nettype wire

// ==== pat_pc.sv ====
`default_nettype none

module pat_pc #(
	parameter int i_adr_width = 10
) (
	input wire clk,
	input wire reset,
	input wire i_taken,
	input wire [i_adr_width-1:0] i_target,
	output logic [i_adr_width-1:0] o_pc
);

	// fetch address, registered straight to the program rom
	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_taken)
			o_pc <= i_target; // redirect, decode drops the two younger words
		else
			o_pc <= o_pc + 1'b1; // sequential fetch
	end

	// target comes from the commit stage adder
	a_target_known: assert property (@(posedge clk) disable iff (reset)
		i_taken |-> !$isunknown(i_target))
		else $error("pat_pc: branch taken with unknown target");

endmodule

`default_nettype wire

// ==== pat_exec_if.sv ====
`default_nettype none

// one decoded instruction sitting in the execute stage
interface pat_exec_if #(
	parameter int i_adr_width = 10
);
	import pat_pkg::*;

	logic ex_valid; // slot holds a live instruction
	alu_op_e alu_op; // same op goes to both alus
	logic use_imm; // 1: take the immediate alu result
	dest_e dest;
	cond_e cond; // only looked at by bf
	rf_addr_t rd; // write-back register, also rn
	data_t reg_value; // forwarded rn for the register alu
	data_t src_value; // rn or selected input for the immediate alu
	data_t imm_value; // zero-extended imm3 or raw imm8
	logic [i_adr_width-1:0] ex_pc; // pc of this instruction, base for bf

	modport decode (output ex_valid, alu_op, use_imm, dest, cond, rd,
		reg_value, src_value, imm_value, ex_pc);
	modport alu (input alu_op, reg_value, src_value, imm_value);
	modport commit (input ex_valid, use_imm, dest, cond, rd, ex_pc, imm_value);

endinterface

`default_nettype wire

// ==== pat_pkg.sv ====
`default_nettype none

package pat_pkg;

	// ========================================
	// widths and basic types
	// ========================================
	localparam int d_width = 8; // datapath width
	localparam int rf_depth = 8; // general registers
	localparam int op_width = 4; // all three opcode tiers are four bits

	typedef logic [d_width-1:0] data_t;
	typedef logic [$clog2(rf_depth)-1:0] rf_addr_t;
	typedef logic [22:0] instr_t; // rn, reserved, cond, reserved, op_i8, imm8

	// field positions, low to high
	localparam int imm8_lsb = 0;
	localparam int op_i8_lsb = 8; // bit 12 above it is reserved
	localparam int cond_lsb = 13; // bits 15..19 reserved
	localparam int rn_lsb = 20;
	localparam int op_i3_lsb = 4; // position inside imm8
	localparam int op_i0_lsb = 0; // position inside imm8, shares bits with imm3
	localparam int imm3_width = 3;

	// all-ones opcode escapes to the next tier
	localparam logic [op_width-1:0] prefix_op = 4'hf;

	// ========================================
	// opcodes
	// ========================================
	typedef enum logic [op_width-1:0] {
		op_ori = 4'd0,
		op_orr = 4'd1,
		op_andi = 4'd2,
		op_andr = 4'd3,
		op_addi = 4'd4,
		op_addr = 4'd5,
		op_subi = 4'd6,
		op_subr = 4'd7,
		op_ldi = 4'd8,
		op_bf = 4'd13 // forward branch, offset in imm8
	} op_i8_e;

	typedef enum logic [op_width-1:0] {
		op_shlzi = 4'd0,
		op_shlzr = 4'd1,
		op_shloi = 4'd2,
		op_shlor = 4'd3,
		op_shrzi = 4'd4,
		op_shrzr = 4'd5,
		op_asri = 4'd6,
		op_asrr = 4'd7,
		op_in = 4'd8, // imm3 is one-hot input select
		op_out = 4'd11
	} op_i3_e;

	typedef enum logic [op_width-1:0] {
		op_not = 4'd0,
		op_test = 4'd2, // sets z and n from rn
		op_nop = 4'd15
	} op_i0_e;

	typedef enum logic [3:0] {
		alu_pass_a, alu_pass_b, alu_or, alu_and, alu_add, alu_sub,
		alu_not, alu_shlz, alu_shlo, alu_shrz, alu_asr
	} alu_op_e;

	typedef enum logic [2:0] {
		dest_none, dest_reg, dest_out, dest_flags, dest_branch
	} dest_e;

	typedef enum logic [1:0] {
		cond_z = 2'd0,
		cond_nz = 2'd1,
		cond_n = 2'd2,
		cond_al = 2'd3
	} cond_e;

	// i3 prefix, i0 prefix, then nop
	localparam instr_t instr_nop = {11'b0, prefix_op, prefix_op, op_nop};

endpackage

`default_nettype wire
